//--- common/decode_pkg.sv
package decode_pkg;

   localparam int XLEN = 32;
   localparam int LG_REGS = 5;

   typedef logic [XLEN-1:0] xlen_t;
   typedef logic [31:0] insn_t;
   typedef logic [LG_REGS-1:0] reg_idx_t;

   typedef enum logic [6:0]
   {
      OPC_LOAD     = 7'h03,
      OPC_MISC_MEM = 7'h0f,
      OPC_OP_IMM   = 7'h13,
      OPC_AUIPC    = 7'h17,
      OPC_STORE    = 7'h23,
      OPC_OP       = 7'h33,
      OPC_LUI      = 7'h37,
      OPC_BRANCH   = 7'h63,
      OPC_JALR     = 7'h67,
      OPC_JAL      = 7'h6f
   } opcode_t;

   typedef enum logic [5:0]
   {
      II, NOP,
      LB, LH, LW, LBU, LHU, SB, SH, SW,
      ADDI, SLLI, SLTI, SLTIU, XORI, SRLI, SRAI, ORI, ANDI,
      ADDU, SUBU, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
      MUL, MULH, MULHU, DIV, DIVU, REM, REMU,
      LUI, AUIPC,
      BEQ, BNE, BLT, BGE, BLTU, BGEU,
      J, JAL, JR, JALR, RET
   } uop_op_t;

   // which immediate the decoder wants, pc-relative kinds are summed with pc
   typedef enum logic [2:0]
   {
      IMM_NONE,
      IMM_I,
      IMM_S,
      IMM_U,
      IMM_PC_U,
      IMM_PC_B,
      IMM_PC_J
   } imm_kind_t;

   localparam logic [6:0] FUNCT7_BASE = 7'h00;
   localparam logic [6:0] FUNCT7_ALT = 7'h20; // sub, sra, srai
   localparam logic [6:0] FUNCT7_MULDIV = 7'h01;

   localparam logic [4:0] LINK_RA = 5'd1;
   localparam logic [4:0] LINK_T0 = 5'd5; // alternate link register

endpackage

//--- decode/imm_gen.sv
`timescale 1ns/1ps

module imm_gen (
   input  decode_pkg::insn_t     insn,
   input  decode_pkg::xlen_t     pc,
   input  decode_pkg::imm_kind_t imm_kind,
   output decode_pkg::xlen_t     imm
);
   import decode_pkg::*;

   xlen_t imm_i;
   xlen_t imm_s;
   xlen_t imm_b;
   xlen_t imm_u;
   xlen_t imm_j;
   xlen_t pc_off;
   xlen_t pc_sum;

   assign imm_i = {{(XLEN-12){insn[31]}}, insn[31:20]};
   assign imm_s = {{(XLEN-12){insn[31]}}, insn[31:25], insn[11:7]};
   assign imm_b = {{(XLEN-12){insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
   assign imm_u = {insn[31:12], 12'd0};
   assign imm_j = {{(XLEN-20){insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};

   // single adder shared by auipc, branches and jal
   always_comb
   begin
      case (imm_kind)
         IMM_PC_B: pc_off = imm_b;
         IMM_PC_J: pc_off = imm_j;
         default:  pc_off = imm_u;
      endcase
   end

   assign pc_sum = pc + pc_off;

   always_comb
   begin
      case (imm_kind)
         IMM_I:    imm = imm_i;
         IMM_S:    imm = imm_s;
         IMM_U:    imm = imm_u; // lui
         IMM_PC_U,
         IMM_PC_B,
         IMM_PC_J: imm = pc_sum;
         default:  imm = '0;
      endcase
   end

endmodule

//--- decode/op_decode.sv
`timescale 1ns/1ps

module op_decode (
   input  decode_pkg::insn_t     insn,
   input  logic                  insn_pred,
   output decode_pkg::uop_op_t   op,
   output decode_pkg::imm_kind_t imm_kind,
   output decode_pkg::reg_idx_t  dst,
   output decode_pkg::reg_idx_t  src_a,
   output decode_pkg::reg_idx_t  src_b,
   output logic                  dst_valid,
   output logic                  src_a_valid,
   output logic                  src_b_valid,
   output logic                  is_br,
   output logic                  br_pred,
   output logic                  is_mem,
   output logic                  is_store,
   output logic                  is_int,
   output logic                  is_cheap_int
);
   import decode_pkg::*;

   opcode_t opcode;
   reg_idx_t rd;
   reg_idx_t rs1;
   reg_idx_t rs2;
   logic [2:0] funct3;
   logic [6:0] funct7;
   logic alt;
   logic rd_nz;
   logic rs1_link;

   assign opcode = opcode_t'(insn[6:0]);
   assign rd = insn[11:7];
   assign rs1 = insn[19:15];
   assign rs2 = insn[24:20];
   assign funct3 = insn[14:12];
   assign funct7 = insn[31:25];
   assign alt = (funct7 == FUNCT7_ALT);
   assign rd_nz = (rd != '0);
   assign rs1_link = (rs1 == LINK_RA) || (rs1 == LINK_T0);

   always_comb
   begin
      op = II;
      imm_kind = IMM_NONE;
      dst = '0;
      src_a = '0;
      src_b = '0;
      dst_valid = 1'b0;
      src_a_valid = 1'b0;
      src_b_valid = 1'b0;
      is_br = 1'b0;
      br_pred = 1'b0;
      is_mem = 1'b0;
      is_store = 1'b0;
      is_int = 1'b0;
      is_cheap_int = 1'b0;

      case (opcode)
         OPC_LOAD:
         begin
            dst = rd;
            src_a = rs1;
            dst_valid = rd_nz;
            src_a_valid = 1'b1;
            is_mem = 1'b1;
            imm_kind = IMM_I;
            case (funct3)
               3'd0:    op = LB;
               3'd1:    op = LH;
               3'd2:    op = LW;
               3'd4:    op = LBU;
               3'd5:    op = LHU;
               default: op = II;
            endcase
         end
         OPC_STORE:
         begin
            src_a = rs1;
            src_b = rs2;
            src_a_valid = 1'b1;
            src_b_valid = 1'b1;
            is_mem = 1'b1;
            is_store = 1'b1;
            imm_kind = IMM_S;
            case (funct3)
               3'd0:    op = SB;
               3'd1:    op = SH;
               3'd2:    op = SW;
               default: op = II;
            endcase
         end
         OPC_OP_IMM:
         begin
            dst = rd;
            src_a = rs1;
            dst_valid = rd_nz;
            src_a_valid = rd_nz; // no read needed when result is dropped
            is_int = 1'b1;
            is_cheap_int = 1'b1;
            imm_kind = IMM_I;
            case (funct3)
               3'd0: op = ADDI;
               3'd1: op = (funct7 == FUNCT7_BASE) ? SLLI : II;
               3'd2: op = SLTI;
               3'd3: op = SLTIU;
               3'd4: op = XORI;
               3'd5: op = (funct7 == FUNCT7_BASE) ? SRLI : (alt ? SRAI : II);
               3'd6: op = ORI;
               3'd7: op = ANDI;
            endcase
            if (!rd_nz && op != II)
               op = NOP;
         end
         OPC_OP:
         begin
            dst = rd;
            src_a = rs1;
            src_b = rs2;
            dst_valid = rd_nz;
            src_a_valid = 1'b1;
            src_b_valid = 1'b1;
            is_int = 1'b1;
            if (funct7 == FUNCT7_MULDIV)
            begin
               case (funct3)
                  3'd0:    op = MUL;
                  3'd1:    op = MULH;
                  3'd3:    op = MULHU;
                  3'd4:    op = DIV;
                  3'd5:    op = DIVU;
                  3'd6:    op = REM;
                  3'd7:    op = REMU;
                  default: op = II; // no mulhsu
               endcase
            end
            else if (funct7 == FUNCT7_BASE || alt)
            begin
               is_cheap_int = 1'b1;
               case (funct3)
                  3'd0: op = alt ? SUBU : ADDU;
                  3'd1: op = alt ? II : SLL;
                  3'd2: op = alt ? II : SLT;
                  3'd3: op = alt ? II : SLTU;
                  3'd4: op = alt ? II : XOR;
                  3'd5: op = alt ? SRA : SRL;
                  3'd6: op = alt ? II : OR;
                  3'd7: op = alt ? II : AND;
               endcase
            end
            if (!rd_nz && op != II)
               op = NOP;
         end
         OPC_LUI, OPC_AUIPC:
         begin
            dst = rd;
            dst_valid = rd_nz;
            is_int = 1'b1;
            is_cheap_int = 1'b1;
            if (opcode == OPC_LUI)
            begin
               op = rd_nz ? LUI : NOP;
               imm_kind = IMM_U;
            end
            else
            begin
               op = rd_nz ? AUIPC : NOP;
               imm_kind = IMM_PC_U;
            end
         end
         OPC_BRANCH:
         begin
            src_a = rs1;
            src_b = rs2;
            src_a_valid = 1'b1;
            src_b_valid = 1'b1;
            is_int = 1'b1;
            is_br = 1'b1;
            is_cheap_int = 1'b1;
            br_pred = insn_pred;
            imm_kind = IMM_PC_B;
            case (funct3)
               3'd0:    op = BEQ;
               3'd1:    op = BNE;
               3'd4:    op = BLT;
               3'd5:    op = BGE;
               3'd6:    op = BLTU;
               3'd7:    op = BGEU;
               default: op = II;
            endcase
         end
         OPC_JALR:
         begin
            src_a = rs1;
            src_a_valid = 1'b1;
            is_int = 1'b1;
            is_br = 1'b1;
            is_cheap_int = 1'b1;
            br_pred = 1'b1; // always taken
            imm_kind = IMM_I;
            if (!rd_nz)
               op = rs1_link ? RET : JR;
            else
            begin
               op = JALR;
               dst = rd;
               dst_valid = 1'b1;
            end
         end
         OPC_JAL:
         begin
            is_int = 1'b1;
            is_br = 1'b1;
            br_pred = 1'b1;
            imm_kind = IMM_PC_J;
            if (!rd_nz)
               op = J;
            else
            begin
               op = JAL;
               dst = rd;
               dst_valid = 1'b1;
               is_cheap_int = 1'b1;
            end
         end
         OPC_MISC_MEM: op = NOP; // fence
         default:      op = II;
      endcase

      // illegal words carry nothing downstream
      if (op == II)
      begin
         imm_kind = IMM_NONE;
         dst = '0;
         src_a = '0;
         src_b = '0;
         dst_valid = 1'b0;
         src_a_valid = 1'b0;
         src_b_valid = 1'b0;
         is_br = 1'b0;
         br_pred = 1'b0;
         is_mem = 1'b0;
         is_store = 1'b0;
         is_int = 1'b0;
         is_cheap_int = 1'b0;
      end
   end

endmodule

//--- decode/uop_queue.sv
`timescale 1ns/1ps

module uop_queue (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 in_valid,
   output logic                 in_ready,
   output logic                 out_valid,
   input  logic                 out_ready,
   input  decode_pkg::uop_op_t  op,
   input  decode_pkg::xlen_t    pc,
   input  decode_pkg::xlen_t    imm,
   input  decode_pkg::reg_idx_t dst,
   input  logic                 dst_valid,
   input  decode_pkg::reg_idx_t src_a,
   input  logic                 src_a_valid,
   input  decode_pkg::reg_idx_t src_b,
   input  logic                 src_b_valid,
   input  logic                 is_br,
   input  logic                 br_pred,
   input  logic                 is_mem,
   input  logic                 is_store,
   input  logic                 is_int,
   input  logic                 is_cheap_int,
   output decode_pkg::uop_op_t  uop_op,
   output decode_pkg::xlen_t    uop_pc,
   output decode_pkg::xlen_t    uop_imm,
   output decode_pkg::reg_idx_t uop_dst,
   output logic                 uop_dst_valid,
   output decode_pkg::reg_idx_t uop_src_a,
   output logic                 uop_src_a_valid,
   output decode_pkg::reg_idx_t uop_src_b,
   output logic                 uop_src_b_valid,
   output logic                 uop_is_br,
   output logic                 uop_br_pred,
   output logic                 uop_is_mem,
   output logic                 uop_is_store,
   output logic                 uop_is_int,
   output logic                 uop_is_cheap_int
);
   import decode_pkg::*;

   typedef struct packed {
      uop_op_t  op;
      xlen_t    pc;
      xlen_t    imm;
      reg_idx_t dst;
      reg_idx_t src_a;
      reg_idx_t src_b;
      logic [8:0] bits; // valid bits and class flags
   } entry_t;

   entry_t mem [2];
   entry_t wr_entry;
   entry_t rd_entry;
   logic wr_ptr;
   logic rd_ptr;
   logic [1:0] count;
   logic push;
   logic pop;

   assign in_ready = (count != 2'd2);
   assign out_valid = (count != 2'd0);
   assign push = in_valid && in_ready;
   assign pop = out_valid && out_ready;

   assign wr_entry.op = op;
   assign wr_entry.pc = pc;
   assign wr_entry.imm = imm;
   assign wr_entry.dst = dst;
   assign wr_entry.src_a = src_a;
   assign wr_entry.src_b = src_b;
   assign wr_entry.bits = {dst_valid, src_a_valid, src_b_valid, is_br, br_pred,
                           is_mem, is_store, is_int, is_cheap_int};

   always_ff @(posedge clk)
   begin
      if (push)
         mem[wr_ptr] <= wr_entry;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wr_ptr <= 1'b0;
         rd_ptr <= 1'b0;
         count <= 2'd0;
      end
      else
      begin
         if (push)
            wr_ptr <= ~wr_ptr;
         if (pop)
            rd_ptr <= ~rd_ptr;
         case ({push, pop})
            2'b10:   count <= count + 2'd1;
            2'b01:   count <= count - 2'd1;
            default: count <= count; // idle or pass-through
         endcase
      end
   end

   assign rd_entry = mem[rd_ptr];
   assign uop_op = rd_entry.op;
   assign uop_pc = rd_entry.pc;
   assign uop_imm = rd_entry.imm;
   assign uop_dst = rd_entry.dst;
   assign uop_src_a = rd_entry.src_a;
   assign uop_src_b = rd_entry.src_b;
   assign {uop_dst_valid, uop_src_a_valid, uop_src_b_valid, uop_is_br, uop_br_pred,
           uop_is_mem, uop_is_store, uop_is_int, uop_is_cheap_int} = rd_entry.bits;

endmodule

//--- decode/decode_riscv.sv
`timescale 1ns/1ps

module decode_riscv (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 insn_valid,
   output logic                 insn_ready,
   input  decode_pkg::insn_t    insn,
   input  decode_pkg::xlen_t    pc,
   input  logic                 insn_pred,
   output logic                 uop_valid,
   input  logic                 uop_ready,
   output decode_pkg::uop_op_t  uop_op,
   output decode_pkg::xlen_t    uop_pc,
   output decode_pkg::xlen_t    uop_imm,
   output decode_pkg::reg_idx_t uop_dst,
   output logic                 uop_dst_valid,
   output decode_pkg::reg_idx_t uop_src_a,
   output logic                 uop_src_a_valid,
   output decode_pkg::reg_idx_t uop_src_b,
   output logic                 uop_src_b_valid,
   output logic                 uop_is_br,
   output logic                 uop_br_pred,
   output logic                 uop_is_mem,
   output logic                 uop_is_store,
   output logic                 uop_is_int,
   output logic                 uop_is_cheap_int
);
   import decode_pkg::*;

   // decoded fields, named after the ports they join
   uop_op_t op;
   imm_kind_t imm_kind;
   xlen_t imm;
   reg_idx_t dst;
   reg_idx_t src_a;
   reg_idx_t src_b;
   logic dst_valid;
   logic src_a_valid;
   logic src_b_valid;
   logic is_br;
   logic br_pred;
   logic is_mem;
   logic is_store;
   logic is_int;
   logic is_cheap_int;

   op_decode op_decode_i (.*);

   imm_gen imm_gen_i (.*);

   uop_queue uop_queue_i (
      .*,
      .in_valid  (insn_valid),
      .in_ready  (insn_ready),
      .out_valid (uop_valid),
      .out_ready (uop_ready)
   );

endmodule

//--- tests/decode_props.sv
`timescale 1ns/1ps

module decode_props (
   input logic                 clk,
   input logic                 rst,
   input logic                 insn_ready,
   input logic                 uop_valid,
   input logic                 uop_ready,
   input decode_pkg::uop_op_t  uop_op,
   input decode_pkg::xlen_t    uop_pc,
   input decode_pkg::xlen_t    uop_imm,
   input decode_pkg::reg_idx_t uop_dst,
   input decode_pkg::reg_idx_t uop_src_a,
   input decode_pkg::reg_idx_t uop_src_b,
   input logic                 uop_dst_valid,
   input logic                 uop_src_a_valid,
   input logic                 uop_src_b_valid,
   input logic                 uop_is_br,
   input logic                 uop_br_pred,
   input logic                 uop_is_mem,
   input logic                 uop_is_store,
   input logic                 uop_is_int,
   input logic                 uop_is_cheap_int
);
   import decode_pkg::*;

   hold_while_stalled: assert property (@(posedge clk) disable iff (rst)
      uop_valid && !uop_ready |=> uop_valid &&
         $stable({uop_op, uop_pc, uop_imm, uop_dst, uop_src_a, uop_src_b,
                  uop_dst_valid, uop_src_a_valid, uop_src_b_valid,
                  uop_is_br, uop_br_pred, uop_is_mem, uop_is_store,
                  uop_is_int, uop_is_cheap_int}))
      else $error("micro-op changed while stalled");

   empty_after_reset: assert property (@(posedge clk) rst |=> !uop_valid)
      else $error("uop_valid high after reset");

   full_means_valid: assert property (@(posedge clk) disable iff (rst)
      !insn_ready |-> uop_valid)
      else $error("insn_ready low with no micro-op pending");

endmodule

//--- tests/decode_model.svh
// expected micro-op, one field per DUT output
typedef struct packed {
   uop_op_t  op;
   xlen_t    pc;
   xlen_t    imm;
   reg_idx_t dst;
   reg_idx_t src_a;
   reg_idx_t src_b;
   logic     dst_valid;
   logic     src_a_valid;
   logic     src_b_valid;
   logic     is_br;
   logic     br_pred;
   logic     is_mem;
   logic     is_store;
   logic     is_int;
   logic     is_cheap_int;
} uop_t;

function automatic reg_idx_t pick_link_reg();
   case ({$random(seed)} % 3)
      0:       return 5'd0;
      1:       return LINK_RA;
      default: return LINK_T0;
   endcase
endfunction

// weighted opcode mix, a few raw words stay illegal
function automatic insn_t gen_insn();
   insn_t w;
   int sel;
   w = $random(seed);
   sel = {$random(seed)} % 24;
   if (sel < 3)
      w[6:0] = OPC_LOAD;
   else if (sel < 5)
      w[6:0] = OPC_STORE;
   else if (sel < 9)
      w[6:0] = OPC_OP_IMM;
   else if (sel < 13)
      w[6:0] = OPC_OP;
   else if (sel == 13)
      w[6:0] = OPC_LUI;
   else if (sel == 14)
      w[6:0] = OPC_AUIPC;
   else if (sel < 18)
      w[6:0] = OPC_BRANCH;
   else if (sel < 20)
      w[6:0] = OPC_JALR;
   else if (sel == 20)
      w[6:0] = OPC_JAL;
   else if (sel == 21)
      w[6:0] = OPC_MISC_MEM;
   if (sel >= 5 && sel < 13)
   begin
      case ({$random(seed)} % 4)
         0: w[31:25] = FUNCT7_BASE;
         1: w[31:25] = FUNCT7_ALT;
         2: w[31:25] = FUNCT7_MULDIV;
         default: ; // keep random bits
      endcase
   end
   if ({$random(seed)} % 3 == 0)
      w[11:7] = pick_link_reg();
   if ({$random(seed)} % 3 == 0)
      w[19:15] = pick_link_reg();
   return w;
endfunction

function automatic uop_t ref_decode(insn_t w, xlen_t pc, logic pred);
   uop_t u;
   logic signed [31:0] sw;
   logic [6:0] opc;
   logic [2:0] f3;
   logic [6:0] f7;
   reg_idx_t rd;
   reg_idx_t rs1;
   reg_idx_t rs2;
   xlen_t imm_i;
   xlen_t imm_s;
   xlen_t imm_b;
   xlen_t imm_u;
   xlen_t imm_j;

   opc = w[6:0];
   f3 = w[14:12];
   f7 = w[31:25];
   rd = w[11:7];
   rs1 = w[19:15];
   rs2 = w[24:20];
   sw = w;
   sw = sw >>> 20;
   imm_i = sw;
   imm_s = {imm_i[31:5], w[11:7]};
   imm_b = {imm_s[31:12], w[7], imm_s[10:1], 1'b0};
   imm_u = w & 32'hfffff000;
   imm_j = {imm_i[31:20], w[19:12], w[20], imm_i[10:1], 1'b0};

   u = '0;
   u.pc = pc;
   case (opc)
      OPC_LOAD:
      begin
         case (f3)
            3'd0:    u.op = LB;
            3'd1:    u.op = LH;
            3'd2:    u.op = LW;
            3'd4:    u.op = LBU;
            3'd5:    u.op = LHU;
            default: u.op = II;
         endcase
         u.dst = rd;
         u.dst_valid = (rd != 0);
         u.src_a = rs1;
         u.src_a_valid = 1'b1;
         u.is_mem = 1'b1;
         u.imm = imm_i;
      end
      OPC_STORE:
      begin
         case (f3)
            3'd0:    u.op = SB;
            3'd1:    u.op = SH;
            3'd2:    u.op = SW;
            default: u.op = II;
         endcase
         u.src_a = rs1;
         u.src_b = rs2;
         u.src_a_valid = 1'b1;
         u.src_b_valid = 1'b1;
         u.is_mem = 1'b1;
         u.is_store = 1'b1;
         u.imm = imm_s;
      end
      OPC_OP_IMM:
      begin
         case (f3)
            3'd0: u.op = ADDI;
            3'd1: u.op = (f7 == 7'h00) ? SLLI : II;
            3'd2: u.op = SLTI;
            3'd3: u.op = SLTIU;
            3'd4: u.op = XORI;
            3'd5: u.op = (f7 == 7'h00) ? SRLI : ((f7 == 7'h20) ? SRAI : II);
            3'd6: u.op = ORI;
            3'd7: u.op = ANDI;
         endcase
         u.dst = rd;
         u.src_a = rs1;
         u.dst_valid = (rd != 0);
         u.src_a_valid = (rd != 0);
         u.is_int = 1'b1;
         u.is_cheap_int = 1'b1;
         u.imm = imm_i;
      end
      OPC_OP:
      begin
         if (f7 == 7'h01)
         begin
            case (f3)
               3'd0:    u.op = MUL;
               3'd1:    u.op = MULH;
               3'd3:    u.op = MULHU;
               3'd4:    u.op = DIV;
               3'd5:    u.op = DIVU;
               3'd6:    u.op = REM;
               3'd7:    u.op = REMU;
               default: u.op = II;
            endcase
         end
         else if (f7 == 7'h00)
         begin
            case (f3)
               3'd0: u.op = ADDU;
               3'd1: u.op = SLL;
               3'd2: u.op = SLT;
               3'd3: u.op = SLTU;
               3'd4: u.op = XOR;
               3'd5: u.op = SRL;
               3'd6: u.op = OR;
               3'd7: u.op = AND;
            endcase
         end
         else if (f7 == 7'h20 && f3 == 3'd0)
            u.op = SUBU;
         else if (f7 == 7'h20 && f3 == 3'd5)
            u.op = SRA;
         else
            u.op = II;
         u.dst = rd;
         u.src_a = rs1;
         u.src_b = rs2;
         u.dst_valid = (rd != 0);
         u.src_a_valid = 1'b1;
         u.src_b_valid = 1'b1;
         u.is_int = 1'b1;
         u.is_cheap_int = (f7 != 7'h01);
      end
      OPC_LUI, OPC_AUIPC:
      begin
         u.op = (opc == OPC_LUI) ? LUI : AUIPC;
         u.dst = rd;
         u.dst_valid = (rd != 0);
         u.is_int = 1'b1;
         u.is_cheap_int = 1'b1;
         u.imm = (opc == OPC_LUI) ? imm_u : pc + imm_u;
      end
      OPC_BRANCH:
      begin
         case (f3)
            3'd0:    u.op = BEQ;
            3'd1:    u.op = BNE;
            3'd4:    u.op = BLT;
            3'd5:    u.op = BGE;
            3'd6:    u.op = BLTU;
            3'd7:    u.op = BGEU;
            default: u.op = II;
         endcase
         u.src_a = rs1;
         u.src_b = rs2;
         u.src_a_valid = 1'b1;
         u.src_b_valid = 1'b1;
         u.is_int = 1'b1;
         u.is_br = 1'b1;
         u.is_cheap_int = 1'b1;
         u.br_pred = pred;
         u.imm = pc + imm_b;
      end
      OPC_JALR:
      begin
         if (rd != 0)
         begin
            u.op = JALR;
            u.dst = rd;
            u.dst_valid = 1'b1;
         end
         else if (rs1 == 5'd1 || rs1 == 5'd5)
            u.op = RET;
         else
            u.op = JR;
         u.src_a = rs1;
         u.src_a_valid = 1'b1;
         u.is_int = 1'b1;
         u.is_br = 1'b1;
         u.is_cheap_int = 1'b1;
         u.br_pred = 1'b1;
         u.imm = imm_i;
      end
      OPC_JAL:
      begin
         u.op = (rd != 0) ? JAL : J;
         u.dst = rd;
         u.dst_valid = (rd != 0);
         u.is_cheap_int = (rd != 0); // plain jump is not cheap
         u.is_int = 1'b1;
         u.is_br = 1'b1;
         u.br_pred = 1'b1;
         u.imm = pc + imm_j;
      end
      OPC_MISC_MEM: u.op = NOP; // fence
      default:      u.op = II;
   endcase

   // integer result into x0 is dropped
   if (rd == 0 && u.op != II &&
       (opc == OPC_OP_IMM || opc == OPC_OP || opc == OPC_LUI || opc == OPC_AUIPC))
      u.op = NOP;

   if (u.op == II)
   begin
      u = '0;
      u.pc = pc;
   end
   return u;
endfunction

//--- tests/decode_tb.sv
`timescale 1ns/1ps

module decode_tb;
   import decode_pkg::*;

   localparam int N_INSNS = 3000;
   localparam int TIMEOUT = 100; // cycles per wait

   integer seed = 15;

   `include "decode_model.svh"

   logic clk;
   logic rst;
   logic insn_valid;
   logic insn_ready;
   insn_t insn;
   xlen_t pc;
   logic insn_pred;
   logic uop_valid;
   logic uop_ready;
   uop_op_t uop_op;
   xlen_t uop_pc;
   xlen_t uop_imm;
   reg_idx_t uop_dst;
   logic uop_dst_valid;
   reg_idx_t uop_src_a;
   logic uop_src_a_valid;
   reg_idx_t uop_src_b;
   logic uop_src_b_valid;
   logic uop_is_br;
   logic uop_br_pred;
   logic uop_is_mem;
   logic uop_is_store;
   logic uop_is_int;
   logic uop_is_cheap_int;

   uop_t expq[$];
   int n_compared = 0;

   decode_riscv decode_riscv_i (.*);

   bind decode_riscv decode_props decode_props_i (.*);

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic abort_run(string why);
      $display("%s", why);
      $display("Errors found");
      $fatal(1);
   endtask

   task automatic check_op(string name, uop_op_t exp, uop_op_t got);
      if (got !== exp)
      begin
         $display("error at %0t: %s expected %s got %s", $time, name, exp.name(), got.name());
         abort_run("micro-op operation mismatch");
      end
   endtask

   task automatic check_reg(string name, reg_idx_t exp, reg_idx_t got);
      if (got !== exp)
      begin
         $display("error at %0t: %s expected %0d got %0d", $time, name, exp, got);
         abort_run("register index mismatch");
      end
   endtask

   task automatic check_word(string name, xlen_t exp, xlen_t got);
      if (got !== exp)
      begin
         $display("error at %0t: %s expected %h got %h", $time, name, exp, got);
         abort_run("word mismatch");
      end
   endtask

   task automatic check_flag(string name, logic exp, logic got);
      if (got !== exp)
      begin
         $display("error at %0t: %s expected %b got %b", $time, name, exp, got);
         abort_run("flag mismatch");
      end
   endtask

   // sink stalls about a quarter of the cycles
   initial
   begin
      uop_ready = 1'b0;
      forever
      begin
         @(posedge clk);
         #1 uop_ready = ({$random(seed)} % 4) != 0;
      end
   end

   // compare at negedge where handshake and fields are settled
   initial
   begin
      uop_t got;
      uop_t exp;
      uop_t held;
      logic stalled;
      stalled = 1'b0;
      held = '0;
      forever
      begin
         @(negedge clk);
         if (rst)
            stalled = 1'b0;
         else
         begin
            if (!insn_ready && !uop_valid)
               abort_run("insn_ready low while no micro-op is pending");
            if (stalled && !uop_valid)
               abort_run("uop_valid dropped while stalled");
            if (uop_valid)
            begin
               got = '{uop_op, uop_pc, uop_imm, uop_dst, uop_src_a, uop_src_b,
                       uop_dst_valid, uop_src_a_valid, uop_src_b_valid, uop_is_br,
                       uop_br_pred, uop_is_mem, uop_is_store, uop_is_int,
                       uop_is_cheap_int};
               if (stalled && got !== held)
                  abort_run("micro-op fields changed while stalled");
               if (uop_ready)
               begin
                  if (expq.size() == 0)
                     abort_run("micro-op delivered with no instruction pending");
                  exp = expq.pop_front();
                  check_op("uop_op", exp.op, got.op);
                  check_word("uop_pc", exp.pc, got.pc);
                  check_word("uop_imm", exp.imm, got.imm);
                  check_reg("uop_dst", exp.dst, got.dst);
                  check_reg("uop_src_a", exp.src_a, got.src_a);
                  check_reg("uop_src_b", exp.src_b, got.src_b);
                  check_flag("uop_dst_valid", exp.dst_valid, got.dst_valid);
                  check_flag("uop_src_a_valid", exp.src_a_valid, got.src_a_valid);
                  check_flag("uop_src_b_valid", exp.src_b_valid, got.src_b_valid);
                  check_flag("uop_is_br", exp.is_br, got.is_br);
                  check_flag("uop_br_pred", exp.br_pred, got.br_pred);
                  check_flag("uop_is_mem", exp.is_mem, got.is_mem);
                  check_flag("uop_is_store", exp.is_store, got.is_store);
                  check_flag("uop_is_int", exp.is_int, got.is_int);
                  check_flag("uop_is_cheap_int", exp.is_cheap_int, got.is_cheap_int);
                  n_compared++;
               end
            end
            stalled = uop_valid && !uop_ready;
            held = got;
         end
      end
   end

   // source
   initial
   begin
      int n;
      int wait_cnt;
      rst = 1'b1;
      insn_valid = 1'b0;
      insn = '0;
      pc = '0;
      insn_pred = 1'b0;
      repeat (5) @(posedge clk);
      #1 rst = 1'b0;
      check_flag("uop_valid", 1'b0, uop_valid);
      check_flag("insn_ready", 1'b1, insn_ready);

      for (n = 0; n < N_INSNS; n++)
      begin
         if ({$random(seed)} % 8 == 0)
         begin
            insn_valid = 1'b0; // idle gap
            @(posedge clk);
            #1;
         end
         insn_valid = 1'b1;
         insn = gen_insn();
         pc = $random(seed);
         pc[1:0] = 2'b00;
         insn_pred = ({$random(seed)} % 2) != 0;
         wait_cnt = 0;
         while (!insn_ready)
         begin
            @(posedge clk);
            #1;
            wait_cnt++;
            if (wait_cnt > TIMEOUT)
               abort_run("timeout waiting for insn_ready");
         end
         expq.push_back(ref_decode(insn, pc, insn_pred)); // accepted at next edge
         @(posedge clk);
         #1;
      end
      insn_valid = 1'b0;

      wait_cnt = 0;
      while (expq.size() != 0)
      begin
         @(posedge clk);
         #1;
         wait_cnt++;
         if (wait_cnt > TIMEOUT)
            abort_run("timeout waiting for the last micro-ops");
      end
      @(posedge clk);
      #1;

      if (n_compared == N_INSNS)
      begin
         $display("No errors");
         $finish;
      end
      else
         abort_run("micro-op count wrong at end of run");
   end

endmodule

//--- sim.f
+incdir+tests
common/decode_pkg.sv
decode/imm_gen.sv
decode/op_decode.sv
decode/uop_queue.sv
decode/decode_riscv.sv
tests/decode_props.sv
tests/decode_tb.sv
